// File: iwm_flux.f
+incdir+testbench
verilog/iwm_pkg.sv
verilog/flux_window_decoder.sv
verilog/iwm_data_latch.sv
verilog/iwm_read_mux.sv
verilog/iwm_flux_top.sv
testbench/tb_iwm_flux.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the IWM flux read path testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f iwm_flux.f \
    --top-module tb_iwm_flux -o tb_iwm_flux > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_iwm_flux > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

# Verdict comes from the log
if grep -qF "*** FAILED ***" "$SIM_LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0

// File: testbench/iwm_flux_model.svh
// ==============================
// IWM read path reference model
// Flux cell encoding and register read rules
// ==============================

`ifndef IWM_FLUX_MODEL_SVH
`define IWM_FLUX_MODEL_SVH

// Cell length in 14 MHz cycles, short cells for 3.5 inch or fast mode
function automatic int cell_cycles(input logic is35, input logic fast);
    if (is35 || fast) begin
        return 28;
    end
    return 56;
endfunction

// One cycle pulse in the middle of a cell that carries a 1
function automatic logic flux_level(input logic [7:0] disk_byte, input logic [2:0] bit_idx,
                                    input int cycle, input int cell_len);
    return disk_byte[bit_idx] && (cycle == cell_len / 2);
endfunction

// Sense, zero, motor on with disk, mode bits 4 to 0
function automatic logic [7:0] status_byte(input logic sense, input logic mounted,
                                           input logic motor, input logic [7:0] mode);
    return {sense, 1'b0, motor && mounted, mode[4:0]};
endfunction

// Register selected by the effective Q7 and Q6
function automatic logic [7:0] register_read(input logic q7, input logic q6, input logic motor,
                                             input logic [7:0] data, input logic [7:0] status);
    if (!q7 && !q6) begin
        return motor ? data : 8'hFF;
    end else if (!q7) begin
        return status;
    end else if (!q6) begin
        return 8'h80;
    end
    return 8'hFF;
endfunction

`endif

// File: testbench/tb_iwm_flux.sv
// ==============================
// IWM flux read path testbench
// Random disk bytes, CPU polling and register checks
// ==============================

`timescale 1ns/1ps

module tb_iwm_flux;

    localparam int CLK_PERIOD = 40;
    localparam int N_BYTES    = 12;
    // Lead-in cell and two trailing cells around each stream
    localparam int STREAM_CELLS    = N_BYTES * 8 + 3;
    localparam int WATCHDOG_CYCLES = 4 * STREAM_CELLS * 56 + 3000;
    // Async clear done at most 4 + 2 * 14 cycles after the first read of a byte
    // Polls from this one on read zero
    localparam int CLEAR_READS = (4 + 2 * 14 + 11) / 12;

    logic                   CLK_14M;
    logic                   RESET;
    logic                   clk_7m_en;
    logic                   flux_transition;
    iwm_pkg::cpu_bus_s      cpu;
    iwm_pkg::switches_s     sw;
    iwm_pkg::drive_status_s drive;
    logic [7:0]             data_out;

    logic [31:0] lfsr;
    logic [7:0]  sent[$];
    logic [7:0]  got[$];
    logic        stream_done;

    `include "iwm_flux_model.svh"

    iwm_flux_top DUT (
        .CLK_14M         (CLK_14M),
        .RESET           (RESET),
        .clk_7m_en       (clk_7m_en),
        .cpu             (cpu),
        .sw              (sw),
        .drive           (drive),
        .flux_transition (flux_transition),
        .data_out        (data_out)
    );

    // ==============================
    // Clock, enable and watchdog
    // ==============================

    initial begin
        CLK_14M = 1'b0;
        forever #(CLK_PERIOD / 2) CLK_14M = ~CLK_14M;
    end

    // 7 MHz enable on every other cycle
    initial begin
        clk_7m_en <= 1'b0;
        forever begin
            @(posedge CLK_14M);
            clk_7m_en <= ~clk_7m_en;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_now("watchdog timeout, the tests did not finish in time");
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            fail_now($sformatf("mismatch in %s: expected %02h, actual %02h",
                               name, expected, actual));
        end
    endtask

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    // Three cycle read, sampled mid first cycle
    task automatic cpu_read(input logic [3:0] addr, output logic [7:0] value);
        @(posedge CLK_14M);
        cpu.addr <= addr;
        cpu.rd   <= 1'b1;
        cpu.cen  <= 1'b1;
        @(negedge CLK_14M);
        value = data_out;
        repeat (3) @(posedge CLK_14M);
        cpu.rd  <= 1'b0;
        cpu.cen <= 1'b0;
    endtask

    // ==============================
    // Disk stream and CPU polling
    // ==============================

    task automatic send_stream(input int cell_len);
        // Empty lead-in cell while the window FSM leaves IDLE
        repeat (cell_len) @(posedge CLK_14M);
        foreach (sent[i]) begin
            for (int b = 7; b >= 0; b--) begin
                for (int c = 0; c < cell_len; c++) begin
                    @(posedge CLK_14M);
                    flux_transition <= flux_level(sent[i], b[2:0], c, cell_len);
                end
            end
        end
        // Room for the last byte to complete
        repeat (2 * cell_len) @(posedge CLK_14M);
        stream_done = 1'b1;
    endtask

    // Read every 12 cycles, each new byte with bit 7 set is the next one sent
    task automatic poll_stream(input string name, input logic async_mode);
        logic [7:0] v;
        logic [7:0] last;
        logic [7:0] expected;
        logic       have_byte;
        int         idx;
        int         reads_after;
        last        = 8'h00;
        have_byte   = 1'b0;
        reads_after = 0;
        while (!stream_done) begin
            cpu_read(4'h0, v);
            if (v[7] && (!have_byte || v != last)) begin
                idx = got.size();
                check_value($sformatf("%s byte %0d", name, idx),
                            (idx < sent.size()) ? sent[idx] : 8'h00, v);
                got.push_back(v);
                last        = sent[idx];
                have_byte   = 1'b1;
                reads_after = 0;
            end else begin
                reads_after++;
                if (!have_byte) begin
                    // Nothing decoded yet
                    expected = 8'h00;
                end else if (!async_mode) begin
                    // Sync mode holds the byte until the next one
                    expected = last;
                end else if (v == 8'h00 || reads_after >= CLEAR_READS) begin
                    // Async clear has run out
                    expected = 8'h00;
                end else begin
                    // Bit 7 masked after the first read
                    expected = {1'b0, last[6:0]};
                end
                check_value(name, expected, v);
            end
            repeat (8) @(posedge CLK_14M);
        end
    endtask

    task automatic run_stream(input string name, input logic is35, input logic fast,
                              input logic async_mode);
        logic [7:0] b;
        logic [7:0] prev;
        logic [7:0] v;
        int         cell_len;
        // Stop the drive
        @(posedge CLK_14M);
        drive.motor_active   <= 1'b0;
        drive.motor_spinning <= 1'b0;
        drive.disk_ready     <= 1'b0;
        drive.disk_mounted   <= 1'b1;
        drive.is_35_inch     <= is35;
        sw.q6   <= 1'b0;
        sw.q7   <= 1'b0;
        // Mode bit 3 fast cells, bit 1 async
        sw.mode <= {4'b0000, fast, 1'b0, async_mode, 1'b0};
        repeat (3) @(posedge CLK_14M);
        // Motor start from standstill empties the data register
        drive.motor_active <= 1'b1;
        repeat (3) @(posedge CLK_14M);
        cpu_read(4'h0, v);
        check_value($sformatf("%s motor start", name),
                    register_read(1'b0, 1'b0, 1'b1, 8'h00, 8'h00), v);
        // Neighbouring bytes differ so repeats mark the same byte
        sent.delete();
        got.delete();
        prev = 8'h00;
        for (int i = 0; i < N_BYTES; i++) begin
            do begin
                take_bits(8, b);
                b[7] = 1'b1;
            end while (b == prev);
            sent.push_back(b);
            prev = b;
        end
        cell_len    = cell_cycles(is35, fast);
        stream_done = 1'b0;
        drive.motor_spinning <= 1'b1;
        drive.disk_ready     <= 1'b1;
        fork
            send_stream(cell_len);
            poll_stream(name, async_mode);
        join
        check_value($sformatf("%s byte count", name), 8'(sent.size()), 8'(got.size()));
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        logic [7:0] v;
        logic [7:0] r;
        logic [7:0] mode;
        lfsr            = 32'hec9331a6;
        stream_done     = 1'b0;
        RESET           <= 1'b1;
        flux_transition <= 1'b0;
        cpu             <= '0;
        sw              <= '0;
        drive           <= '0;
        repeat (10) @(posedge CLK_14M);
        RESET <= 1'b0;
        repeat (2) @(posedge CLK_14M);

        // Motor off register reads
        cpu_read(4'h0, v);
        check_value("idle data", register_read(1'b0, 1'b0, 1'b0, 8'h00, 8'h00), v);
        @(posedge CLK_14M);
        sw.q7 <= 1'b1;
        cpu_read(4'h0, v);
        check_value("handshake", register_read(1'b1, 1'b0, 1'b0, 8'h00, 8'h00), v);
        // Q6 switch address read with Q7 set
        cpu_read(4'hD, v);
        check_value("q7 and q6 set", register_read(1'b1, 1'b1, 1'b0, 8'h00, 8'h00), v);
        @(posedge CLK_14M);
        sw.q7 <= 1'b0;
        cpu_read(4'hF, v);
        check_value("handshake by q7 address",
                    register_read(1'b1, 1'b0, 1'b0, 8'h00, 8'h00), v);

        // Status by switch state or by the Q6 address itself
        for (int i = 0; i < 16; i++) begin
            take_bits(8, mode);
            take_bits(4, r);
            @(posedge CLK_14M);
            drive.sense        <= r[0];
            drive.disk_mounted <= r[1];
            drive.motor_active <= r[2];
            sw.mode <= mode;
            sw.q6   <= !r[3];
            cpu_read(r[3] ? 4'hD : 4'h0, v);
            check_value($sformatf("status %0d", i),
                        register_read(1'b0, 1'b1, r[2], 8'h00,
                                      status_byte(r[0], r[1], r[2], mode)), v);
        end

        run_stream("sync 3.5 inch", 1'b1, 1'b0, 1'b0);
        run_stream("sync 5.25 inch slow", 1'b0, 1'b0, 1'b0);
        run_stream("sync 5.25 inch fast", 1'b0, 1'b1, 1'b0);
        run_stream("async 3.5 inch", 1'b1, 1'b0, 1'b1);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: verilog/iwm_flux_top.sv
// ==============================
// IWM flux read path top level
// ==============================

`timescale 1ns/1ps

module iwm_flux_top (
    input  logic                     CLK_14M,
    input  logic                     RESET,
    input  logic                     clk_7m_en,
    input  iwm_pkg::cpu_bus_s        cpu,
    input  iwm_pkg::switches_s       sw,
    input  iwm_pkg::drive_status_s   drive,
    input  logic                     flux_transition,
    output logic [7:0]               data_out
);

    // Decoder to latch
    logic [7:0] rsh;
    logic       byte_completing;

    // Between latch and mux
    logic       data_access;
    logic [7:0] data_value;

    flux_window_decoder u_decoder (
        .CLK_14M         (CLK_14M),
        .RESET           (RESET),
        .flux_transition (flux_transition),
        .drive           (drive),
        .sw              (sw),
        .rsh             (rsh),
        .byte_completing (byte_completing)
    );

    iwm_data_latch u_latch (
        .CLK_14M         (CLK_14M),
        .RESET           (RESET),
        .clk_7m_en       (clk_7m_en),
        .cpu             (cpu),
        .sw              (sw),
        .drive           (drive),
        .rsh             (rsh),
        .byte_completing (byte_completing),
        .data_access     (data_access),
        .data_value      (data_value)
    );

    // Combinational register select
    iwm_read_mux u_mux (
        .cpu         (cpu),
        .sw          (sw),
        .drive       (drive),
        .data_value  (data_value),
        .data_access (data_access),
        .data_out    (data_out)
    );

endmodule

// File: verilog/iwm_read_mux.sv
// ==============================
// IWM register read mux
// Q7/Q6 select of data, status and handshake
// ==============================

`timescale 1ns/1ps

module iwm_read_mux (
    input  iwm_pkg::cpu_bus_s        cpu,
    input  iwm_pkg::switches_s       sw,
    input  iwm_pkg::drive_status_s   drive,
    input  logic [7:0]               data_value,
    output logic                     data_access,
    output logic [7:0]               data_out
);

    logic       imm_q6;
    logic       imm_q7;
    logic [7:0] status_reg;

    // An access to a Q6 or Q7 switch uses the new value at once
    assign imm_q6 = (cpu.addr[3:1] == iwm_pkg::Q6_ADDR_HI) ? cpu.addr[0] : sw.q6;
    assign imm_q7 = (cpu.addr[3:1] == iwm_pkg::Q7_ADDR_HI) ? cpu.addr[0] : sw.q7;

    // Data register read in progress
    assign data_access = cpu.rd && cpu.cen && !imm_q7 && !imm_q6;

    // Sense, reserved zero, motor on with disk, low mode bits
    assign status_reg = {drive.sense, 1'b0, drive.motor_active && drive.disk_mounted,
                         sw.mode[4:0]};

    always_comb begin
        case ({imm_q7, imm_q6})
            2'b00: begin
                data_out = drive.motor_active ? data_value : iwm_pkg::IDLE_READ_VALUE;
            end
            2'b01: begin
                data_out = status_reg;
            end
            2'b10: begin
                data_out = iwm_pkg::HANDSHAKE_VALUE;
            end
            default: begin
                data_out = iwm_pkg::IDLE_READ_VALUE;
            end
        endcase
    end

endmodule

// File: verilog/iwm_data_latch.sv
// ==============================
// IWM data register
// Byte latch, bit 7 acknowledge and async clear countdown
// ==============================

`timescale 1ns/1ps

module iwm_data_latch (
    input  logic                     CLK_14M,
    input  logic                     RESET,
    input  logic                     clk_7m_en,
    input  iwm_pkg::cpu_bus_s        cpu,
    input  iwm_pkg::switches_s       sw,
    input  iwm_pkg::drive_status_s   drive,
    input  logic [7:0]               rsh,
    input  logic                     byte_completing,
    input  logic                     data_access,
    output logic [7:0]               data_value
);

    logic [7:0] data_reg;
    logic [7:0] data_raw;
    logic [5:0] async_cnt;
    logic       data_read;
    logic       rd_latched;
    logic       bit7_ack;
    logic       motor_was_on;
    logic       is_async;
    logic       rd_active;
    logic       decoder_active;

    assign is_async       = sw.mode[iwm_pkg::MODE_ASYNC_BIT];
    assign rd_active      = cpu.rd && cpu.cen;
    assign decoder_active = drive.motor_spinning && drive.disk_ready;

    // Same cycle bypass of a completing byte
    assign data_raw = byte_completing ? rsh : data_reg;

    // Bit 7 hidden once the CPU has seen it in async mode
    assign data_value = (drive.motor_active && is_async && bit7_ack && !byte_completing)
                      ? (data_raw & 8'h7F) : data_raw;

    // ==============================
    // Register and handshake state
    // ==============================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            data_reg     <= 8'h00;
            async_cnt    <= '0;
            data_read    <= 1'b1;
            rd_latched   <= 1'b0;
            bit7_ack     <= 1'b0;
            motor_was_on <= 1'b0;
        end else begin
            motor_was_on <= drive.motor_active;

            // Motor start from standstill in read mode
            if (drive.motor_active && !motor_was_on && !sw.q7 && !drive.motor_spinning) begin
                data_reg <= 8'h00;
            end

            // Async clear countdown on the 7 MHz enable
            if (clk_7m_en && (async_cnt != 6'd0)) begin
                if ((async_cnt == 6'd1) && is_async && !byte_completing) begin
                    data_reg <= 8'h00;
                    bit7_ack <= 1'b0;
                end
                async_cnt <= async_cnt - 6'd1;
            end

            // New byte wins over the clear and the mask
            if (byte_completing) begin
                data_reg  <= rsh;
                data_read <= 1'b0;
                bit7_ack  <= 1'b0;
                async_cnt <= '0;
            end

            if (!decoder_active) begin
                bit7_ack  <= 1'b0;
                async_cnt <= '0;
            end

            // End of a CPU access
            if (!rd_active) begin
                // Acknowledge only a data read that saw bit 7
                if (rd_latched && drive.motor_active && is_async && data_raw[7] &&
                    data_read && !byte_completing) begin
                    bit7_ack <= 1'b1;
                    if (async_cnt == 6'd0) begin
                        async_cnt <= iwm_pkg::ASYNC_CLEAR_TICKS;
                    end
                end
                rd_latched <= 1'b0;
            end

            // First cycle of a CPU access
            if (rd_active && !rd_latched) begin
                rd_latched <= 1'b1;
                if (data_access) begin
                    data_read <= 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/flux_window_decoder.sv
// ==============================
// Flux window decoder
// Turns flux edges into bit cells and assembles disk bytes
// ==============================

`timescale 1ns/1ps

module flux_window_decoder (
    input  logic                     CLK_14M,
    input  logic                     RESET,
    input  logic                     flux_transition,
    input  iwm_pkg::drive_status_s   drive,
    input  iwm_pkg::switches_s       sw,
    output logic [7:0]               rsh,
    output logic                     byte_completing
);

    iwm_pkg::rd_state_e state;
    iwm_pkg::window_t   window_cnt;
    iwm_pkg::window_t   full_win;
    iwm_pkg::window_t   half_win;

    logic prev_flux;
    logic flux_seen;
    logic flux_pending;
    logic flux_edge;
    logic active;
    logic fast_cells;

    // Decoder only runs with a spinning motor and valid track data
    assign active = drive.motor_spinning && drive.disk_ready;

    // 28 cycle cells for 3.5 inch drives or in fast mode
    assign fast_cells = drive.is_35_inch || sw.mode[iwm_pkg::MODE_FAST_BIT];
    assign full_win   = fast_cells ? iwm_pkg::FULL_WIN_FAST : iwm_pkg::FULL_WIN_SLOW;
    assign half_win   = fast_cells ? iwm_pkg::HALF_WIN_FAST : iwm_pkg::HALF_WIN_SLOW;

    // Rising edge of the flux line
    assign flux_edge = flux_transition && !prev_flux;

    // Byte done once a 1 has reached the MSB
    assign byte_completing = rsh[7] && active;

    // ==============================
    // Window state machine
    // ==============================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            state        <= iwm_pkg::IDLE;
            window_cnt   <= '0;
            rsh          <= 8'h00;
            prev_flux    <= 1'b0;
            flux_seen    <= 1'b0;
            flux_pending <= 1'b0;
        end else begin
            prev_flux <= flux_transition;

            // Edge is acted on one cycle after it arrives
            if (flux_edge) begin
                flux_seen <= 1'b1;
            end

            if (active) begin
                case (state)
                    iwm_pkg::IDLE: begin
                        state      <= iwm_pkg::EDGE_0;
                        window_cnt <= full_win;
                        rsh        <= 8'h00;
                        flux_seen  <= 1'b0;
                    end

                    iwm_pkg::EDGE_0: begin
                        // Fresh edge or one held over from EDGE_1
                        if (flux_seen || flux_pending) begin
                            state        <= iwm_pkg::EDGE_1;
                            window_cnt   <= half_win;
                            flux_seen    <= 1'b0;
                            flux_pending <= 1'b0;
                        end else if (window_cnt == 6'd1) begin
                            // Empty cell
                            rsh        <= {rsh[6:0], 1'b0};
                            window_cnt <= full_win;
                        end else begin
                            window_cnt <= window_cnt - 6'd1;
                        end
                    end

                    iwm_pkg::EDGE_1: begin
                        // Early edge of the next cell, keep it for EDGE_0
                        if (flux_seen) begin
                            flux_pending <= 1'b1;
                            flux_seen    <= 1'b0;
                        end
                        // Half window after the edge, shift in a 1
                        if (window_cnt == 6'd1) begin
                            rsh        <= {rsh[6:0], 1'b1};
                            state      <= iwm_pkg::EDGE_0;
                            window_cnt <= full_win;
                        end else begin
                            window_cnt <= window_cnt - 6'd1;
                        end
                    end

                    default: begin
                        state <= iwm_pkg::IDLE;
                    end
                endcase

                // Completed byte leaves for the data register
                if (rsh[7]) begin
                    rsh <= 8'h00;
                end
            end else begin
                // Motor stopped or no disk
                state        <= iwm_pkg::IDLE;
                window_cnt   <= '0;
                flux_seen    <= 1'b0;
                flux_pending <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/iwm_pkg.sv
// ==============================
// IWM read path shared definitions
// Window lengths, register values, FSM states and bus structs
// ==============================

package iwm_pkg;

    // ==============================
    // Bit-cell timing in 14 MHz cycles
    // ==============================

    typedef logic [5:0] window_t;

    // 3.5 inch drives or fast mode
    localparam window_t FULL_WIN_FAST = 6'd28;
    localparam window_t HALF_WIN_FAST = 6'd14;

    // 5.25 inch drives in normal mode
    localparam window_t FULL_WIN_SLOW = 6'd56;
    localparam window_t HALF_WIN_SLOW = 6'd28;

    // Async clear delay, counted on the 7 MHz enable
    localparam logic [5:0] ASYNC_CLEAR_TICKS = 6'd14;

    // ==============================
    // Register values and decode
    // ==============================

    // Write handshake register as seen by the CPU
    localparam logic [7:0] HANDSHAKE_VALUE = 8'h80;
    // Motor off data reads and the Q7=Q6=1 register
    localparam logic [7:0] IDLE_READ_VALUE = 8'hFF;

    // Mode register bit positions
    localparam int MODE_ASYNC_BIT = 1;
    localparam int MODE_FAST_BIT  = 3;

    // Upper address bits of the Q6 and Q7 soft switches
    localparam logic [2:0] Q6_ADDR_HI = 3'b110;
    localparam logic [2:0] Q7_ADDR_HI = 3'b111;

    // Read window FSM
    typedef enum logic [1:0] {
        IDLE,
        EDGE_0,
        EDGE_1
    } rd_state_e;

    // CPU bus, read strobe qualified by phase-2 enable
    typedef struct packed {
        logic [3:0] addr;
        logic       rd;
        logic       cen;
    } cpu_bus_s;

    // Soft switch state from the switch logic
    typedef struct packed {
        logic       q6;
        logic       q7;
        logic [7:0] mode;
    } switches_s;

    // Status lines from the selected drive
    typedef struct packed {
        logic motor_active;
        logic motor_spinning;
        logic disk_ready;
        logic disk_mounted;
        logic is_35_inch;
        logic sense;
    } drive_status_s;

endpackage
